/* common/sc_defs.svh */
`ifndef SC_DEFS_SVH
`define SC_DEFS_SVH

// Out-of-order tag carried by every request and retire
`define SC_TAG_W 10

// Rewind queue entries for the unretired stores
`define SC_RW_DEPTH 8

// Data array size in 32-bit words
`define SC_MEM_WORDS 16

// Request address width with the word index in bits 5..2
`define SC_ADDR_W 32

`endif

/* common/cache_op_pkg.sv */
`default_nettype none

package cache_op_pkg;

    // Request opcodes where RESTORE only comes from the rewind queue
    typedef enum logic [1:0] {
        NO_OP   = 2'd0,
        LD      = 2'd1,
        ST      = 2'd2,
        RESTORE = 2'd3
    } cache_op_e;

    // Access sizes
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } acc_size_e;

    typedef logic [3:0] byte_en_t; // One bit per byte lane

endpackage

`default_nettype wire

/* common/rewind_pkg.sv */
`default_nettype none

package rewind_pkg;

    `include "sc_defs.svh"

    localparam int RW_WIDX_W = $clog2(`SC_MEM_WORDS); // Word index width

    // Life of a rewind entry
    typedef enum logic [1:0] {
        RW_INVALID = 2'd0,
        RW_PENDING = 2'd1,
        RW_RETIRED = 2'd2,
        RW_FLUSHED = 2'd3
    } rw_state_e;

    typedef struct packed {
        logic [RW_WIDX_W-1:0] widx;     // Word that was overwritten
        logic [31:0]          old_word; // Its value before the store
        logic [`SC_TAG_W-1:0] tag;
    } rw_entry_t;

endpackage

`default_nettype wire

/* common/cache_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

// Request into the execute stage
interface cache_req_if import cache_op_pkg::*; ;
    logic                  valid;
    logic                  ready;
    cache_op_e             op;
    logic [`SC_ADDR_W-1:0] addr;
    logic [31:0]           data;    // Store data already in its lanes
    byte_en_t              byte_en;
    logic [`SC_TAG_W-1:0]  tag;

    modport source (output valid, op, addr, data, byte_en, tag, input ready);
    modport sink (input valid, op, addr, data, byte_en, tag, output ready);
endinterface

// Load response out of the execute stage
interface cache_resp_if;
    logic                 valid;
    logic                 ready;
    logic [31:0]          data;
    logic [`SC_TAG_W-1:0] tag;

    modport source (output valid, data, tag, input ready);
    modport sink (input valid, data, tag, output ready);
endinterface

`default_nettype wire

/* src/req_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

module req_decode import cache_op_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  req_valid,
    output logic                       req_ready,
    input  wire cache_op_e             req_op,
    input  wire logic [`SC_ADDR_W-1:0] req_addr,
    input  wire logic [31:0]           req_data,
    input  wire acc_size_e             req_size,
    input  wire logic [`SC_TAG_W-1:0]  req_tag,
    cache_req_if.source                req,
    input  wire logic                  blocked    // Rewind queue full or restoring
);

    logic     run_q;   // Set once the first edge after reset has passed
    logic     accept;
    logic [1:0] lane_off;
    byte_en_t be_base;

    // Align the lane offset to the access size
    always_comb begin
        case (req_size)
            SZ_BYTE: begin
                lane_off = req_addr[1:0];
                be_base  = 4'b0001;
            end
            SZ_HALF: begin
                lane_off = {req_addr[1], 1'b0};
                be_base  = 4'b0011;
            end
            default: begin
                lane_off = 2'b00;
                be_base  = 4'b1111;
            end
        endcase
    end

    assign req_ready = run_q & ~blocked & (~req.valid | req.ready);
    assign accept    = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q     <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (accept)
                req.valid <= 1'b1;
            else if (req.ready)
                req.valid <= 1'b0;   // Drained into execute
        end
    end

    // Payload only loads on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op      <= req_op;
            req.addr    <= req_addr;
            req.data    <= req_data << {lane_off, 3'b000};
            req.byte_en <= be_base << lane_off;
            req.tag     <= req_tag;
        end
    end

    a_be_nonzero: assert property (@(posedge clk) disable iff (rst)
        req.valid && (req.op == LD || req.op == ST) |-> req.byte_en != '0);

endmodule

`default_nettype wire

/* src/cache_exec.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

module cache_exec import cache_op_pkg::*, rewind_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    cache_req_if.sink    req,
    cache_req_if.sink    rst_req,     // Restores from the rewind queue
    cache_resp_if.source resp,
    output logic         rw_push_valid,
    output rw_entry_t    rw_push_entry
);

    logic [31:0]          mem [`SC_MEM_WORDS];
    logic [RW_WIDX_W-1:0] req_idx;
    logic [31:0]          old_word;
    logic                 req_fire;
    logic                 ld_fire;
    logic                 wr_en;
    logic [RW_WIDX_W-1:0] wr_idx;
    logic [31:0]          wr_data;
    logic [31:0]          wr_mask;

    // Expand lane enables into a bit mask
    function automatic logic [31:0] lane_mask(input byte_en_t be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // Lowest enabled lane gives the load shift
    function automatic logic [1:0] lane_low(input byte_en_t be);
        logic [1:0] off;
        off = 2'd3;
        for (int i = 3; i >= 0; i--)
            if (be[i]) off = 2'(i);
        return off;
    endfunction

    assign rst_req.ready = 1'b1;   // Restores always win
    assign req.ready     = ~rst_req.valid & (~resp.valid | resp.ready);
    assign req_fire      = req.valid & req.ready;
    assign ld_fire       = req_fire & (req.op == LD);

    assign req_idx  = req.addr[RW_WIDX_W+1:2];
    assign old_word = mem[req_idx];   // Read before the store writes

    // Pick the write source with restores first
    always_comb begin
        if (rst_req.valid) begin
            wr_en   = rst_req.op == RESTORE;
            wr_idx  = rst_req.addr[RW_WIDX_W+1:2];
            wr_data = rst_req.data;
            wr_mask = lane_mask(rst_req.byte_en);
        end else begin
            wr_en   = req_fire & (req.op == ST);
            wr_idx  = req_idx;
            wr_data = req.data;
            wr_mask = lane_mask(req.byte_en);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SC_MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (wr_en) begin
            mem[wr_idx] <= (mem[wr_idx] & ~wr_mask) | (wr_data & wr_mask);
        end
    end

    // Old word goes to the rewind queue with the store's tag
    assign rw_push_valid          = req_fire & (req.op == ST);
    assign rw_push_entry.widx     = req_idx;
    assign rw_push_entry.old_word = old_word;
    assign rw_push_entry.tag      = req.tag;

    always_ff @(posedge clk) begin
        if (rst)
            resp.valid <= 1'b0;
        else if (~resp.valid | resp.ready)
            resp.valid <= ld_fire;
    end

    always_ff @(posedge clk) begin
        if (ld_fire) begin
            resp.data <= (old_word & lane_mask(req.byte_en)) >> {lane_low(req.byte_en), 3'b000};
            resp.tag  <= req.tag;
        end
    end

    a_no_push_on_restore: assert property (@(posedge clk) disable iff (rst)
        rst_req.valid && rst_req.ready |-> !rw_push_valid);

endmodule

`default_nettype wire

/* src/resp_result.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

module resp_result (
    input  wire logic                 clk,
    input  wire logic                 rst,
    cache_resp_if.sink                resp,
    output logic                      resp_valid,
    input  wire logic                 resp_ready,
    output logic [31:0]               resp_data,
    output logic [`SC_TAG_W-1:0]      resp_tag
);

    logic load_new;

    assign resp.ready = ~resp_valid | resp_ready;   // Empty or draining
    assign load_new   = resp.valid & resp.ready;

    always_ff @(posedge clk) begin
        if (rst)
            resp_valid <= 1'b0;
        else if (load_new)
            resp_valid <= 1'b1;
        else if (resp_ready)
            resp_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load_new) begin
            resp_data <= resp.data;
            resp_tag  <= resp.tag;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_tag));

endmodule

`default_nettype wire

/* rewind/meta_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module meta_queue import rewind_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     push,
    input  wire rw_entry_t                push_entry,
    input  wire logic                     pop_head,    // Oldest entry leaves
    input  wire logic                     pop_tail,    // Newest entry leaves
    input  wire logic [DEPTH-1:0]         state_wr,
    input  wire rw_state_e                state_new [DEPTH],
    output rw_entry_t                     entries [DEPTH],
    output rw_state_e                     states [DEPTH],
    output logic [$clog2(DEPTH)-1:0]      head_idx,
    output logic [$clog2(DEPTH)-1:0]      tail_idx,
    output logic                          full,
    output logic                          empty
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [IDX_W-1:0] wr_ptr;   // Next free slot
    logic [CNT_W-1:0] count;

    function automatic logic [IDX_W-1:0] nxt(input logic [IDX_W-1:0] i);
        return (i == IDX_W'(DEPTH - 1)) ? '0 : i + 1'b1;
    endfunction

    function automatic logic [IDX_W-1:0] prv(input logic [IDX_W-1:0] i);
        return (i == '0) ? IDX_W'(DEPTH - 1) : i - 1'b1;
    endfunction

    assign tail_idx = prv(wr_ptr);
    assign full     = count == CNT_W'(DEPTH);
    assign empty    = count == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_idx <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            for (int i = 0; i < DEPTH; i++)
                states[i] <= RW_INVALID;
        end else begin
            for (int i = 0; i < DEPTH; i++)
                if (state_wr[i]) states[i] <= state_new[i];
            if (pop_head) begin
                states[head_idx] <= RW_INVALID;
                head_idx         <= nxt(head_idx);
            end
            if (pop_tail)
                states[tail_idx] <= RW_INVALID;
            if (push)
                states[wr_ptr] <= RW_PENDING;
            if (push)
                wr_ptr <= nxt(wr_ptr);
            else if (pop_tail)
                wr_ptr <= tail_idx;   // Step back over the restored slot
            count <= count + CNT_W'(push) - CNT_W'(pop_head) - CNT_W'(pop_tail);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= push_entry;
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

`default_nettype wire

/* rewind/rewind_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

module rewind_queue import cache_op_pkg::*, rewind_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 rob_valid,
    input  wire logic [`SC_TAG_W-1:0] rob_ret_tag,
    input  wire logic                 rob_resteer,
    input  wire logic                 rw_push_valid,
    input  wire rw_entry_t            rw_push_entry,
    cache_req_if.source               restore,
    output logic                      blocked,
    output logic                      rewind_full,
    output logic                      rewind_busy
);

    localparam int DEPTH = `SC_RW_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    rw_entry_t        entries [DEPTH];
    rw_state_e        states [DEPTH];
    rw_state_e        state_new [DEPTH];
    logic [DEPTH-1:0] state_wr;
    logic [DEPTH-1:0] is_flushed;
    logic [DEPTH-1:0] is_valid;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic             full;
    logic             empty;
    logic             pop_head;
    logic             pop_tail;
    logic             almost_full;

    // Retire wins over resteer for the matching entry
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            logic pend;
            logic hit;
            pend          = states[i] == RW_PENDING;
            hit           = pend & rob_valid & (entries[i].tag == rob_ret_tag);
            state_wr[i]   = hit | (pend & rob_resteer);
            state_new[i]  = hit ? RW_RETIRED : RW_FLUSHED;
            is_flushed[i] = states[i] == RW_FLUSHED;
            is_valid[i]   = states[i] != RW_INVALID;
        end
    end

    assign pop_head = ~empty & (states[head_idx] == RW_RETIRED);

    // Undo newest first so repeated stores to a word end on the oldest value
    assign restore.valid   = ~empty & (states[tail_idx] == RW_FLUSHED);
    assign restore.op      = RESTORE;
    assign restore.addr    = {{(`SC_ADDR_W-RW_WIDX_W-2){1'b0}}, entries[tail_idx].widx, 2'b00};
    assign restore.data    = entries[tail_idx].old_word;
    assign restore.byte_en = 4'b1111;
    assign restore.tag     = entries[tail_idx].tag;
    assign pop_tail        = restore.valid & restore.ready;

    assign almost_full = $countones(is_valid) == DEPTH - 1;
    assign rewind_full = full;
    assign rewind_busy = |is_flushed;
    assign blocked     = full | rewind_busy | (rw_push_valid & almost_full); // Room for one

    meta_queue #(.DEPTH(DEPTH)) queue_i (
        .clk        (clk),
        .rst        (rst),
        .push       (rw_push_valid),
        .push_entry (rw_push_entry),
        .pop_head   (pop_head),
        .pop_tail   (pop_tail),
        .state_wr   (state_wr),
        .state_new  (state_new),
        .entries    (entries),
        .states     (states),
        .head_idx   (head_idx),
        .tail_idx   (tail_idx),
        .full       (full),
        .empty      (empty)
    );

endmodule

`default_nettype wire

/* src/spec_cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

module spec_cache_top import cache_op_pkg::*, rewind_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  req_valid,
    output logic                       req_ready,
    input  wire cache_op_e             req_op,
    input  wire logic [`SC_ADDR_W-1:0] req_addr,
    input  wire logic [31:0]           req_data,
    input  wire acc_size_e             req_size,
    input  wire logic [`SC_TAG_W-1:0]  req_tag,
    input  wire logic                  rob_valid,
    input  wire logic [`SC_TAG_W-1:0]  rob_ret_tag,
    input  wire logic                  rob_resteer,
    output logic                       resp_valid,
    input  wire logic                  resp_ready,
    output logic [31:0]                resp_data,
    output logic [`SC_TAG_W-1:0]       resp_tag,
    output logic                       rewind_full,
    output logic                       rewind_busy
);

    cache_req_if  dec_req ();
    cache_req_if  rst_req ();
    cache_resp_if exec_resp ();

    logic      blocked;
    logic      rw_push_valid;
    rw_entry_t rw_push_entry;

    req_decode decode_i (
        .clk, .rst, .req_valid, .req_ready, .req_op, .req_addr,
        .req_data, .req_size, .req_tag,
        .req     (dec_req.source),
        .blocked (blocked)
    );

    cache_exec exec_i (
        .clk, .rst,
        .req     (dec_req.sink),
        .rst_req (rst_req.sink),
        .resp    (exec_resp.source),
        .rw_push_valid, .rw_push_entry
    );

    resp_result result_i (
        .clk, .rst,
        .resp (exec_resp.sink),
        .resp_valid, .resp_ready, .resp_data, .resp_tag
    );

    rewind_queue rewind_i (
        .clk, .rst, .rob_valid, .rob_ret_tag, .rob_resteer,
        .rw_push_valid, .rw_push_entry,
        .restore (rst_req.source),
        .blocked, .rewind_full, .rewind_busy
    );

endmodule

`default_nettype wire

/* tests/spec_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sc_defs.svh"

module spec_cache_tb import cache_op_pkg::*; ();

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_ready;
    cache_op_e             req_op;
    logic [`SC_ADDR_W-1:0] req_addr;
    logic [31:0]           req_data;
    acc_size_e             req_size;
    logic [`SC_TAG_W-1:0]  req_tag;
    logic                  rob_valid;
    logic [`SC_TAG_W-1:0]  rob_ret_tag;
    logic                  rob_resteer;
    logic                  resp_valid;
    logic                  resp_ready;
    logic [31:0]           resp_data;
    logic [`SC_TAG_W-1:0]  resp_tag;
    logic                  rewind_full;
    logic                  rewind_busy;

    int tests;
    int checks;
    int errors;
    int cycles;
    int limit;

    // Parsed command file
    logic [63:0]          c_op [$];
    logic [31:0]          c_addr [$];
    logic [31:0]          c_data [$];
    logic [31:0]          c_exp [$];
    int                   c_num [$];
    logic [`SC_TAG_W-1:0] c_tag [$];

    // Reference memory and the unretired stores from oldest to newest
    logic [31:0]          ref_mem [`SC_MEM_WORDS];
    int                   u_widx [$];
    logic [31:0]          u_old [$];
    logic [`SC_TAG_W-1:0] u_tag [$];
    bit                   u_ret [$];

    logic [31:0]          exp_data_q [$];   // Loads in flight
    logic [`SC_TAG_W-1:0] exp_tag_q [$];
    logic [31:0]          mon_data;
    logic [`SC_TAG_W-1:0] mon_tag;

    spec_cache_top dut_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic acc_size_e size_of(input int n);
        case (n)
            1: return SZ_BYTE;
            2: return SZ_HALF;
            default: return SZ_WORD;
        endcase
    endfunction

    // Bit offset of the accessed lanes inside the word
    function automatic int lane_bits(input logic [31:0] addr, input int n);
        case (n)
            1: return 8 * int'(addr[1:0]);
            2: return 16 * int'(addr[1]);
            default: return 0;
        endcase
    endfunction

    function automatic logic [31:0] size_mask(input int n);
        return (n == 4) ? 32'hffff_ffff : (32'h1 << (8 * n)) - 32'h1;
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] addr, input int n);
        return (ref_mem[addr[5:2]] >> lane_bits(addr, n)) & size_mask(n);
    endfunction

    function automatic void model_store(input logic [31:0] addr, input logic [31:0] data,
                                        input int n, input logic [`SC_TAG_W-1:0] tag);
        int          idx;
        logic [31:0] m;
        idx = int'(addr[5:2]);
        m   = size_mask(n) << lane_bits(addr, n);
        u_widx.push_back(idx);
        u_old.push_back(ref_mem[idx]);
        u_tag.push_back(tag);
        u_ret.push_back(1'b0);
        ref_mem[idx] = (ref_mem[idx] & ~m) | ((data << lane_bits(addr, n)) & m);
    endfunction

    function automatic void model_retire(input logic [`SC_TAG_W-1:0] tag);
        foreach (u_tag[i])
            if (!u_ret[i] && u_tag[i] == tag) u_ret[i] = 1'b1;
        while (u_ret.size() > 0 && u_ret[0]) begin   // Retired entries leave from the old end
            void'(u_widx.pop_front());
            void'(u_old.pop_front());
            void'(u_tag.pop_front());
            void'(u_ret.pop_front());
        end
    endfunction

    // Undo newest first
    function automatic void model_resteer();
        for (int i = u_widx.size() - 1; i >= 0; i--) begin
            if (!u_ret[i]) begin
                ref_mem[u_widx[i]] = u_old[i];
                u_widx.delete(i);
                u_old.delete(i);
                u_tag.delete(i);
                u_ret.delete(i);
            end
        end
    endfunction

    task automatic check_load(input logic [31:0] data, input logic [`SC_TAG_W-1:0] tag,
                              input logic [31:0] want, input logic [`SC_TAG_W-1:0] want_tag);
        checks++;
        if (data !== want || tag !== want_tag) begin
            errors++;
            $display("Fail at %0t: load got data %h tag %h, expected data %h tag %h",
                     $time, data, tag, want, want_tag);
        end
    endtask

    task automatic check_status(input string name, input bit got, input bit want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    // Called and left 1 ns after a rising edge
    task automatic issue(input cache_op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input acc_size_e size, input logic [`SC_TAG_W-1:0] tag);
        bit done;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_data  = data;
        req_size  = size;
        req_tag   = tag;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = req_ready;   // Taken at the coming edge
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
    endtask

    task automatic status_checks();
        bit full_now;
        full_now = u_widx.size() == `SC_RW_DEPTH;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_status("rewind_full", rewind_full, full_now);
        if (full_now)
            check_status("req_ready", req_ready, 1'b0);
        check_status("rewind_busy", rewind_busy, 1'b0);
        @(posedge clk);
        #1;
    endtask

    task automatic drain_loads();
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic retire(input logic [`SC_TAG_W-1:0] tag);
        rob_valid   = 1'b1;
        rob_ret_tag = tag;
        @(posedge clk);
        #1;
        rob_valid = 1'b0;
        model_retire(tag);
    endtask

    task automatic resteer();
        bit pending;
        pending = 1'b0;
        foreach (u_ret[i])
            if (!u_ret[i]) pending = 1'b1;
        rob_resteer = 1'b1;
        @(posedge clk);
        #1;
        rob_resteer = 1'b0;
        @(negedge clk);
        check_status("rewind_busy", rewind_busy, pending);
        while (rewind_busy) begin
            check_status("req_ready", req_ready, 1'b0);   // Nothing enters while restoring
            @(negedge clk);
        end
        model_resteer();
        @(posedge clk);
        #1;
    endtask

    // Random back-pressure on the response side
    always begin
        @(posedge clk);
        #1;
        resp_ready = ($urandom % 4) != 0;
    end

    always begin
        @(negedge clk);
        if (resp_valid && resp_ready) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Load response with tag %h arrived while no load was outstanding",
                         resp_tag);
            end else begin
                mon_data = exp_data_q.pop_front();
                mon_tag  = exp_tag_q.pop_front();
                check_load(resp_data, resp_tag, mon_data, mon_tag);
                tests++;
                $display("Test LD tag %h done", mon_tag);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles with the DUT still busy", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int                   fd;
        int                   code;
        int                   ch;
        int                   n;
        logic [63:0]          cmd;
        logic [31:0]          a;
        logic [31:0]          d;
        logic [31:0]          e;
        logic [31:0]          want;
        logic [`SC_TAG_W-1:0] t;
        void'($urandom(32'hdebc_ef2d));
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = NO_OP;
        req_addr    = '0;
        req_data    = '0;
        req_size    = SZ_WORD;
        req_tag     = '0;
        rob_valid   = 1'b0;
        rob_ret_tag = '0;
        rob_resteer = 1'b0;
        resp_ready  = 1'b0;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        limit       = 0;
        foreach (ref_mem[i])
            ref_mem[i] = '0;

        fd = $fopen("tests/spec_cache_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/spec_cache_cases.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                a = '0;
                d = '0;
                e = '0;
                n = 0;
                t = '0;
                code = 0;
                case (cmd)
                    "#": begin
                        ch = $fgetc(fd);
                        while (ch != "\n" && ch != -1)
                            ch = $fgetc(fd);
                    end
                    "ST":   code = $fscanf(fd, "%h %h %d %h", a, d, n, t) - 4;
                    "LD":   code = $fscanf(fd, "%h %d %h %h", a, n, t, e) - 4;
                    "RET":  code = $fscanf(fd, "%h", t) - 1;
                    "IDLE": code = $fscanf(fd, "%d", n) - 1;
                    "RSTR": code = 0;
                    default: code = -1;
                endcase
                if (code != 0) begin
                    errors++;
                    $display("Malformed or unknown command %0s in the cases file", cmd);
                end else if (cmd != "#") begin
                    c_op.push_back(cmd);
                    c_addr.push_back(a);
                    c_data.push_back(d);
                    c_exp.push_back(e);
                    c_num.push_back(n);
                    c_tag.push_back(t);
                end
            end
            $fclose(fd);
        end
        limit = c_op.size() * 40;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < c_op.size(); i++) begin
            case (c_op[i])
                "ST": begin
                    drain_loads();
                    issue(ST, c_addr[i], c_data[i], size_of(c_num[i]), c_tag[i]);
                    model_store(c_addr[i], c_data[i], c_num[i], c_tag[i]);
                    status_checks();
                end
                "LD": begin
                    want = model_load(c_addr[i], c_num[i]);
                    if (want !== c_exp[i]) begin
                        errors++;
                        $display("Cases file expects %h for load tag %h but the model gives %h",
                                 c_exp[i], c_tag[i], want);
                    end
                    issue(LD, c_addr[i], '0, size_of(c_num[i]), c_tag[i]);
                    exp_data_q.push_back(want);
                    exp_tag_q.push_back(c_tag[i]);
                end
                "RET": begin
                    retire(c_tag[i]);
                    status_checks();
                end
                "RSTR": begin
                    drain_loads();
                    resteer();
                    status_checks();
                end
                default: begin
                    repeat ((c_num[i] > 0) ? c_num[i] : 1) @(posedge clk);
                    #1;
                end
            endcase
            if (c_op[i] != "LD") begin
                tests++;
                $display("Test %0d %0s tag %h done", i, c_op[i], c_tag[i]);
            end
        end

        drain_loads();
        repeat (4) @(posedge clk);
        $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/spec_cache_cases.txt */
# ST addr data bytes tag | LD addr bytes tag expected | RET tag | RSTR | IDLE cycles
# addr data tag and expected in hex while bytes and cycles are decimal
# merges of word byte and half stores
ST 00 11223344 4 001
ST 01 000000ab 1 002
ST 06 0000beef 2 003
LD 00 4 004 1122ab44
LD 01 1 005 000000ab
LD 06 2 006 0000beef
RET 001
RET 002
RET 003
# repeated stores to one word are all undone
ST 10 aaaa5555 4 010
ST 10 12345678 4 011
ST 12 00009999 2 012
ST 00 ffffffff 4 013
LD 10 4 014 99995678
RSTR
LD 10 4 015 00000000
LD 00 4 016 1122ab44
# a retired store survives the resteer
ST 20 cafef00d 4 020
ST 24 0badc0de 4 021
RET 020
ST 20 00000001 4 022
ST 24 00000002 4 023
RSTR
LD 20 4 024 cafef00d
LD 24 4 025 00000000
# fill the queue then free one slot and refill it
ST 30 00000030 4 030
ST 34 00000031 4 031
ST 38 00000032 4 032
ST 3c 00000033 4 033
ST 00 00000034 4 034
ST 04 00000035 4 035
ST 08 00000036 4 036
ST 0c 00000037 4 037
RET 030
ST 30 00000038 4 038
IDLE 3
RSTR
LD 30 4 039 00000030
LD 00 4 03a 1122ab44
LD 04 4 03b beef0000
LD 34 4 03c 00000000

/* files.f */
+incdir+common
common/cache_op_pkg.sv
common/rewind_pkg.sv
common/cache_ifs.sv
src/req_decode.sv
src/cache_exec.sv
src/resp_result.sv
rewind/meta_queue.sv
rewind/rewind_queue.sv
src/spec_cache_top.sv
tests/spec_cache_tb.sv

/* Makefile */
# Verilator simulation of the speculative cache slice

VERILATOR ?= verilator
TOP       ?= spec_cache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
